// ==== Makefile ====
# Verilator flow for the sv32 walker subsystem
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_mmu_subsys
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mmu_cfg.svh ====
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// bus widths shared by the walker, memory and cpu port
`define MMU_AW 32
`define MMU_DW 32

// physical memory depth in words
// 8192 words = 32 KB = eight 4 KB pages
`define MEM_WORDS 8192

// cycles allowed per transaction before a run is abandoned
`define MMU_TIMEOUT_BASE 60

// sv32 field widths
`define SV32_PPN_W 20
`define SV32_VPN_W 10

`endif

// ==== mmu_pkg.sv ====
package mmu_pkg;

	// ----------------------------------------
	// page-table walker states
	// ----------------------------------------
	typedef enum logic [3:0] {
		IDLE,
		ISSUE_PTE1,
		WAIT_PTE1,
		ISSUE_PTE2,
		WAIT_PTE2,
		RD_ISSUE,
		RD_WAIT,
		WR_ISSUE,
		WR_AW_PEND,
		WR_W_PEND,
		WR_WAIT_B,
		DONE
	} walk_state_e;

	// response codes, axi encoding
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// config register select
	typedef enum logic {
		REG_SATP   = 1'b0,
		REG_FAULTS = 1'b1
	} reg_sel_e;

endpackage

// ==== mmu_subsys.sv ====
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module mmu_subsys (
	input  logic                 clk,
	input  logic                 rst,
	// cpu port
	input  logic [`MMU_AW-1:0]   in_araddr,
	input  logic                 in_arvalid,
	output logic                 in_arready,
	output logic [`MMU_DW-1:0]   in_rdata,
	output logic [1:0]           in_rresp,
	output logic                 in_rvalid,
	input  logic                 in_rready,
	input  logic [`MMU_AW-1:0]   in_awaddr,
	input  logic                 in_awvalid,
	output logic                 in_awready,
	input  logic [`MMU_DW-1:0]   in_wdata,
	input  logic [`MMU_DW/8-1:0] in_wstrb,
	input  logic                 in_wvalid,
	output logic                 in_wready,
	output logic [1:0]           in_bresp,
	output logic                 in_bvalid,
	input  logic                 in_bready,
	// config port
	input  logic                 cfg_we,
	input  mmu_pkg::reg_sel_e    cfg_sel,
	input  logic [`MMU_DW-1:0]   cfg_wdata,
	output logic [`MMU_DW-1:0]   cfg_rdata
);

	// translation control
	logic                   satp_mode;
	logic [`SV32_PPN_W-1:0] satp_ppn;
	logic                   walk_fault;

	// walker to memory
	logic [`MMU_AW-1:0]     mem_araddr;
	logic                   mem_arvalid;
	logic                   mem_arready;
	logic [`MMU_DW-1:0]     mem_rdata;
	logic [1:0]             mem_rresp;
	logic                   mem_rvalid;
	logic                   mem_rready;
	logic [`MMU_AW-1:0]     mem_awaddr;
	logic                   mem_awvalid;
	logic                   mem_awready;
	logic [`MMU_DW-1:0]     mem_wdata;
	logic [`MMU_DW/8-1:0]   mem_wstrb;
	logic                   mem_wvalid;
	logic                   mem_wready;
	logic [1:0]             mem_bresp;
	logic                   mem_bvalid;
	logic                   mem_bready;

	// all port names match the wires above
	satp_regs u_regs (.*);

	sv32_walker u_walker (.*);

	phys_mem u_mem (.*);

endmodule

// ==== phys_mem.sv ====
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module phys_mem (
	input  logic                 clk,
	input  logic                 rst,
	// read channels
	input  logic [`MMU_AW-1:0]   mem_araddr,
	input  logic                 mem_arvalid,
	output logic                 mem_arready,
	output logic [`MMU_DW-1:0]   mem_rdata,
	output logic [1:0]           mem_rresp,
	output logic                 mem_rvalid,
	input  logic                 mem_rready,
	// write channels
	input  logic [`MMU_AW-1:0]   mem_awaddr,
	input  logic                 mem_awvalid,
	output logic                 mem_awready,
	input  logic [`MMU_DW-1:0]   mem_wdata,
	input  logic [`MMU_DW/8-1:0] mem_wstrb,
	input  logic                 mem_wvalid,
	output logic                 mem_wready,
	output logic [1:0]           mem_bresp,
	output logic                 mem_bvalid,
	input  logic                 mem_bready
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [`MMU_DW-1:0] mem [0:`MEM_WORDS-1];
	logic [IDX_W-1:0]   rd_idx;
	logic [IDX_W-1:0]   wr_idx;
	logic               rd_go;
	logic               wr_go;

	// word index, upper address bits wrap
	assign rd_idx = mem_araddr[IDX_W+1:2];
	assign wr_idx = mem_awaddr[IDX_W+1:2];

	assign mem_arready = !mem_rvalid;
	assign rd_go       = mem_arvalid && mem_arready;

	// aw and w taken in the same cycle only
	assign wr_go       = mem_awvalid && mem_wvalid && !mem_bvalid;
	assign mem_awready = wr_go;
	assign mem_wready  = wr_go;

	assign mem_rresp = mmu_pkg::OKAY;
	assign mem_bresp = mmu_pkg::OKAY;

	// ----------------------------------------
	// storage
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (wr_go) begin
			for (int i = 0; i < `MMU_DW/8; i++) begin
				if (mem_wstrb[i])
					mem[wr_idx][i*8 +: 8] <= mem_wdata[i*8 +: 8];
			end
		end
		if (rd_go)
			mem_rdata <= mem[rd_idx];
	end

	// response holding registers
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_rvalid <= 1'b0;
			mem_bvalid <= 1'b0;
		end else begin
			if (rd_go)
				mem_rvalid <= 1'b1;
			else if (mem_rready)
				mem_rvalid <= 1'b0;
			if (wr_go)
				mem_bvalid <= 1'b1;
			else if (mem_bready)
				mem_bvalid <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		mem_rvalid && !mem_rready |=> mem_rvalid && $stable(mem_rdata))
		else $error("phys_mem: rdata changed while rvalid waited");

endmodule

// ==== satp_regs.sv ====
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module satp_regs (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cfg_we,
	input  mmu_pkg::reg_sel_e      cfg_sel,
	input  logic [`MMU_DW-1:0]     cfg_wdata,
	output logic [`MMU_DW-1:0]     cfg_rdata,
	input  logic                   walk_fault,
	output logic                   satp_mode,
	output logic [`SV32_PPN_W-1:0] satp_ppn
);

	logic [`MMU_DW-1:0] faults;
	logic               wr_satp;
	logic               wr_faults;

	assign wr_satp   = cfg_we && (cfg_sel == mmu_pkg::REG_SATP);
	assign wr_faults = cfg_we && (cfg_sel == mmu_pkg::REG_FAULTS);

	// ----------------------------------------
	// translation register, mode in bit 31
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			satp_mode <= 1'b0;
			satp_ppn  <= '0;
		end else if (wr_satp) begin
			satp_mode <= cfg_wdata[31];
			satp_ppn  <= cfg_wdata[`SV32_PPN_W-1:0];
		end
	end

	// fault counter, saturates at all ones
	always_ff @(posedge clk) begin
		if (rst) begin
			faults <= '0;
		end else if (wr_faults) begin
			faults <= '0;
		end else if (walk_fault && (faults != '1)) begin
			faults <= faults + 1'b1;
		end
	end

	always_comb begin
		case (cfg_sel)
			mmu_pkg::REG_SATP:   cfg_rdata = {satp_mode, 11'b0, satp_ppn};
			mmu_pkg::REG_FAULTS: cfg_rdata = faults;
			default:             cfg_rdata = '0;
		endcase
	end

	// software clears must not race a walk that is faulting
	assert property (@(posedge clk) disable iff (rst) !(walk_fault && wr_faults))
		else $error("satp_regs: walk_fault lost in a REG_FAULTS write cycle");

endmodule

// ==== sources.f ====
+incdir+.
mmu_pkg.sv
satp_regs.sv
sv32_walker.sv
phys_mem.sv
mmu_subsys.sv
tb_mmu_subsys.sv

// ==== sv32_walker.sv ====
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module sv32_walker (
	input  logic                   clk,
	input  logic                   rst,
	// cpu side
	input  logic [`MMU_AW-1:0]     in_araddr,
	input  logic                   in_arvalid,
	output logic                   in_arready,
	output logic [`MMU_DW-1:0]     in_rdata,
	output logic [1:0]             in_rresp,
	output logic                   in_rvalid,
	input  logic                   in_rready,
	input  logic [`MMU_AW-1:0]     in_awaddr,
	input  logic                   in_awvalid,
	output logic                   in_awready,
	input  logic [`MMU_DW-1:0]     in_wdata,
	input  logic [`MMU_DW/8-1:0]   in_wstrb,
	input  logic                   in_wvalid,
	output logic                   in_wready,
	output logic [1:0]             in_bresp,
	output logic                   in_bvalid,
	input  logic                   in_bready,
	// memory side
	output logic [`MMU_AW-1:0]     mem_araddr,
	output logic                   mem_arvalid,
	input  logic                   mem_arready,
	input  logic [`MMU_DW-1:0]     mem_rdata,
	input  logic [1:0]             mem_rresp,
	input  logic                   mem_rvalid,
	output logic                   mem_rready,
	output logic [`MMU_AW-1:0]     mem_awaddr,
	output logic                   mem_awvalid,
	input  logic                   mem_awready,
	output logic [`MMU_DW-1:0]     mem_wdata,
	output logic [`MMU_DW/8-1:0]   mem_wstrb,
	output logic                   mem_wvalid,
	input  logic                   mem_wready,
	input  logic [1:0]             mem_bresp,
	input  logic                   mem_bvalid,
	output logic                   mem_bready,
	// translation control
	input  logic                   satp_mode,
	input  logic [`SV32_PPN_W-1:0] satp_ppn,
	output logic                   walk_fault
);

	mmu_pkg::walk_state_e state;

	logic                   is_wr;
	logic [`MMU_AW-1:0]     vaddr;
	logic [`MMU_DW-1:0]     wdata_q;
	logic [`MMU_DW/8-1:0]   wstrb_q;
	logic [`MMU_DW-1:0]     rdata_q;
	mmu_pkg::resp_e         resp_q;
	logic [`SV32_PPN_W-1:0] root_ppn;
	logic [`SV32_PPN_W-1:0] pte1_ppn;
	logic [`SV32_PPN_W-1:0] pte2_ppn;
	logic [`MMU_AW-1:0]     pte1_addr;
	logic [`MMU_AW-1:0]     pte2_addr;
	logic [`MMU_AW-1:0]     paddr;
	logic                   bare;
	logic                   pte_rx;
	logic                   wr_req;

	// ----------------------------------------
	// address formation
	// ----------------------------------------
	assign pte1_addr = {root_ppn, vaddr[31:22], 2'b00};
	assign pte2_addr = {pte1_ppn, vaddr[21:12], 2'b00};
	assign paddr     = {pte2_ppn, vaddr[11:0]};

	assign bare   = (state == mmu_pkg::IDLE) && !satp_mode;
	assign wr_req = in_awvalid && in_wvalid;
	// pte word accepted from memory
	assign pte_rx = mem_rvalid &&
		((state == mmu_pkg::WAIT_PTE1) || (state == mmu_pkg::WAIT_PTE2));
	assign walk_fault = pte_rx && !mem_rdata[0];

	// ----------------------------------------
	// memory side, bare mode passes through
	// ----------------------------------------
	assign mem_araddr = bare ? in_araddr :
		(state == mmu_pkg::ISSUE_PTE1) ? pte1_addr :
		(state == mmu_pkg::ISSUE_PTE2) ? pte2_addr : paddr;
	assign mem_arvalid = bare ? in_arvalid :
		(state inside {mmu_pkg::ISSUE_PTE1, mmu_pkg::ISSUE_PTE2, mmu_pkg::RD_ISSUE});
	assign mem_rready = bare ? in_rready :
		(state inside {mmu_pkg::WAIT_PTE1, mmu_pkg::WAIT_PTE2, mmu_pkg::RD_WAIT});
	assign mem_awaddr  = bare ? in_awaddr : paddr;
	assign mem_awvalid = bare ? in_awvalid :
		(state inside {mmu_pkg::WR_ISSUE, mmu_pkg::WR_AW_PEND});
	assign mem_wdata  = bare ? in_wdata : wdata_q;
	assign mem_wstrb  = bare ? in_wstrb : wstrb_q;
	assign mem_wvalid = bare ? in_wvalid :
		(state inside {mmu_pkg::WR_ISSUE, mmu_pkg::WR_W_PEND});
	assign mem_bready = bare ? in_bready : (state == mmu_pkg::WR_WAIT_B);

	// cpu side, address accepted together with the response
	assign in_arready = bare ? mem_arready :
		(state == mmu_pkg::DONE) && !is_wr && in_rready;
	assign in_rdata  = bare ? mem_rdata : rdata_q;
	assign in_rresp  = bare ? mem_rresp : resp_q;
	assign in_rvalid = bare ? mem_rvalid : (state == mmu_pkg::DONE) && !is_wr;
	assign in_awready = bare ? mem_awready :
		(state == mmu_pkg::DONE) && is_wr && in_bready;
	assign in_wready = bare ? mem_wready :
		(state == mmu_pkg::DONE) && is_wr && in_bready;
	assign in_bresp  = bare ? mem_bresp : resp_q;
	assign in_bvalid = bare ? mem_bvalid : (state == mmu_pkg::DONE) && is_wr;

	// ----------------------------------------
	// walk fsm
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mmu_pkg::IDLE;
			is_wr <= 1'b0;
		end else begin
			case (state)
				mmu_pkg::IDLE: begin
					// write wins when both directions are requested
					if (satp_mode && wr_req) begin
						is_wr <= 1'b1;
						state <= mmu_pkg::ISSUE_PTE1;
					end else if (satp_mode && in_arvalid) begin
						is_wr <= 1'b0;
						state <= mmu_pkg::ISSUE_PTE1;
					end
				end
				mmu_pkg::ISSUE_PTE1: begin
					if (mem_arready)
						state <= mmu_pkg::WAIT_PTE1;
				end
				mmu_pkg::WAIT_PTE1: begin
					if (mem_rvalid)
						state <= mem_rdata[0] ? mmu_pkg::ISSUE_PTE2 : mmu_pkg::DONE;
				end
				mmu_pkg::ISSUE_PTE2: begin
					if (mem_arready)
						state <= mmu_pkg::WAIT_PTE2;
				end
				mmu_pkg::WAIT_PTE2: begin
					if (mem_rvalid && !mem_rdata[0])
						state <= mmu_pkg::DONE;
					else if (mem_rvalid)
						state <= is_wr ? mmu_pkg::WR_ISSUE : mmu_pkg::RD_ISSUE;
				end
				mmu_pkg::RD_ISSUE: begin
					if (mem_arready)
						state <= mmu_pkg::RD_WAIT;
				end
				mmu_pkg::RD_WAIT: begin
					if (mem_rvalid)
						state <= mmu_pkg::DONE;
				end
				mmu_pkg::WR_ISSUE: begin
					// aw and w may complete in either order
					if (mem_awready && mem_wready)
						state <= mmu_pkg::WR_WAIT_B;
					else if (mem_awready)
						state <= mmu_pkg::WR_W_PEND;
					else if (mem_wready)
						state <= mmu_pkg::WR_AW_PEND;
				end
				mmu_pkg::WR_AW_PEND: begin
					if (mem_awready)
						state <= mmu_pkg::WR_WAIT_B;
				end
				mmu_pkg::WR_W_PEND: begin
					if (mem_wready)
						state <= mmu_pkg::WR_WAIT_B;
				end
				mmu_pkg::WR_WAIT_B: begin
					if (mem_bvalid)
						state <= mmu_pkg::DONE;
				end
				mmu_pkg::DONE: begin
					if (is_wr ? in_bready : in_rready)
						state <= mmu_pkg::IDLE;
				end
				default: state <= mmu_pkg::IDLE;
			endcase
		end
	end

	// request and walk payload
	always_ff @(posedge clk) begin
		if (state == mmu_pkg::IDLE) begin
			// satp sampled once per request
			root_ppn <= satp_ppn;
			vaddr    <= wr_req ? in_awaddr : in_araddr;
			wdata_q  <= in_wdata;
			wstrb_q  <= in_wstrb;
		end
		if (walk_fault) begin
			resp_q  <= mmu_pkg::SLVERR;
			rdata_q <= '0;
		end else if (pte_rx && (state == mmu_pkg::WAIT_PTE1)) begin
			pte1_ppn <= mem_rdata[29:10];
		end else if (pte_rx) begin
			pte2_ppn <= mem_rdata[29:10];
		end
		if ((state == mmu_pkg::RD_WAIT) && mem_rvalid) begin
			rdata_q <= mem_rdata;
			resp_q  <= mmu_pkg::resp_e'(mem_rresp);
		end
		if ((state == mmu_pkg::WR_WAIT_B) && mem_bvalid)
			resp_q <= mmu_pkg::resp_e'(mem_bresp);
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	assert property (@(posedge clk) disable iff (rst) in_rvalid && !in_rready |=> in_rvalid)
		else $error("sv32_walker: in_rvalid dropped before in_rready");

	assert property (@(posedge clk) disable iff (rst)
		!(mem_arvalid &&
		(state inside {mmu_pkg::WR_ISSUE, mmu_pkg::WR_AW_PEND, mmu_pkg::WR_W_PEND})))
		else $error("sv32_walker: mem_arvalid high in walk_state_e %s", state.name());

endmodule

// ==== tb_mmu_subsys.sv ====
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tb_mmu_subsys;

	localparam int FILL_WORDS = 32;
	localparam int N_TABLE    = 7;
	localparam int N_BARE     = 40;
	localparam int N_TRD      = 40;
	localparam int N_TWR      = 30;
	localparam int N_FAULT    = 12;
	// fill and final sweep, bare pairs, walks, write readbacks, faults, config
	localparam int N_TRANS    = 2 * (4 * FILL_WORDS + N_TABLE) + 2 * N_BARE + N_TRD
		+ 2 * N_TWR + N_FAULT + 8;
	localparam int MAX_CYCLES = N_TRANS * `MMU_TIMEOUT_BASE;
	localparam int IDX_HI     = $clog2(`MEM_WORDS) + 1;
	localparam int SAMPLE_DLY = 5;
	localparam logic [19:0] ROOT_PPN = 20'd1;
	localparam logic [19:0] L2_PPN   = 20'd2;
	localparam logic [19:0] DATA_PPN = 20'd4;
	localparam logic [31:0] SATP_ON  = {1'b1, 11'b0, ROOT_PPN};

	logic                 clk;
	logic                 rst;
	logic [`MMU_AW-1:0]   in_araddr;
	logic                 in_arvalid;
	logic                 in_arready;
	logic [`MMU_DW-1:0]   in_rdata;
	logic [1:0]           in_rresp;
	logic                 in_rvalid;
	logic                 in_rready;
	logic [`MMU_AW-1:0]   in_awaddr;
	logic                 in_awvalid;
	logic                 in_awready;
	logic [`MMU_DW-1:0]   in_wdata;
	logic [`MMU_DW/8-1:0] in_wstrb;
	logic                 in_wvalid;
	logic                 in_wready;
	logic [1:0]           in_bresp;
	logic                 in_bvalid;
	logic                 in_bready;
	logic                 cfg_we;
	mmu_pkg::reg_sel_e    cfg_sel;
	logic [`MMU_DW-1:0]   cfg_wdata;
	logic [`MMU_DW-1:0]   cfg_rdata;

	// model of physical memory and the words known to be initialized
	logic [`MMU_DW-1:0] shadow [0:`MEM_WORDS-1];
	logic [`MMU_AW-1:0] known_addrs [$];
	logic [`MMU_AW-1:0] written_pa [$];
	logic [31:0]        lcg_state;
	int                 errors;
	int                 faults_issued;
	int                 cycles = 0;

	mmu_subsys u_dut (.*);

	always #20 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 15);
	endfunction

	function automatic int word_idx(input logic [31:0] addr);
		return int'(addr[IDX_HI:2]);
	endfunction

	function automatic logic [31:0] merge_strb(input logic [31:0] old,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	// two-level sv32 walk over the shadow copy
	// returns 1 when both levels are valid
	function automatic logic translate(input logic [31:0] va, output logic [31:0] pa);
		logic [31:0] pte1;
		logic [31:0] pte2;
		pte1 = shadow[word_idx({ROOT_PPN, va[31:22], 2'b00})];
		pte2 = shadow[word_idx({pte1[29:10], va[21:12], 2'b00})];
		pa = {pte2[29:10], va[11:0]};
		return pte1[0] && pte2[0];
	endfunction

	// first 32 words of virtual pages 0 to 3 in the first 4 MB region
	function automatic logic [31:0] mapped_vaddr(input logic [31:0] r);
		return {10'd0, 8'd0, r[9:8], 5'd0, r[6:2], 2'b00};
	endfunction

	function automatic logic [31:0] data_paddr(input logic [31:0] r);
		return {17'd0, 1'b1, r[9:8], 5'd0, r[6:2], 2'b00};
	endfunction

	task automatic check_eq(input string name, input logic [31:0] addr,
		input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("CHECK FAILED: %s at %h expected %h got %h", name, addr, exp, got);
			errors++;
		end
	endtask

	// ----------------------------------------
	// cpu port transactions
	// ----------------------------------------
	task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		logic        ar_done;
		logic        r_done;
		logic        hold;
		logic [31:0] held_data;
		logic [1:0]  held_resp;
		ar_done = 1'b0;
		r_done  = 1'b0;
		hold    = 1'b0;
		while (!r_done) begin
			@(negedge clk);
			in_araddr  = addr;
			in_arvalid = !ar_done;
			in_rready  = (next_rand() & 32'h3) != 0;
			#SAMPLE_DLY;
			if (hold && !in_rvalid) begin
				$display("in_rvalid dropped before the read of %h was accepted", addr);
				errors++;
			end else if (hold) begin
				check_eq("in_rdata held", addr, held_data, in_rdata);
				check_eq("in_rresp held", addr, 32'(held_resp), 32'(in_rresp));
			end
			if (in_arvalid && in_arready)
				ar_done = 1'b1;
			if (in_rvalid && in_rready) begin
				r_done = 1'b1;
				data   = in_rdata;
				resp   = in_rresp;
			end
			hold      = in_rvalid && !in_rready;
			held_data = in_rdata;
			held_resp = in_rresp;
		end
		@(negedge clk);
		in_arvalid = 1'b0;
		in_rready  = 1'b0;
	endtask

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		logic       aw_done;
		logic       w_done;
		logic       b_done;
		logic       hold;
		logic [1:0] held_resp;
		aw_done = 1'b0;
		w_done  = 1'b0;
		b_done  = 1'b0;
		hold    = 1'b0;
		while (!b_done) begin
			@(negedge clk);
			in_awaddr  = addr;
			in_wdata   = data;
			in_wstrb   = strb;
			in_awvalid = !aw_done;
			in_wvalid  = !w_done;
			in_bready  = (next_rand() & 32'h3) != 0;
			#SAMPLE_DLY;
			if (hold && !in_bvalid) begin
				$display("in_bvalid dropped before the write to %h was accepted", addr);
				errors++;
			end else if (hold) begin
				check_eq("in_bresp held", addr, 32'(held_resp), 32'(in_bresp));
			end
			if (in_awvalid && in_awready)
				aw_done = 1'b1;
			if (in_wvalid && in_wready)
				w_done = 1'b1;
			if (in_bvalid && in_bready) begin
				b_done = 1'b1;
				resp   = in_bresp;
			end
			hold      = in_bvalid && !in_bready;
			held_resp = in_bresp;
		end
		@(negedge clk);
		in_awvalid = 1'b0;
		in_wvalid  = 1'b0;
		in_bready  = 1'b0;
	endtask

	task automatic cfg_write(input mmu_pkg::reg_sel_e sel, input logic [31:0] data);
		@(negedge clk);
		cfg_we    = 1'b1;
		cfg_sel   = sel;
		cfg_wdata = data;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic cfg_read(input mmu_pkg::reg_sel_e sel, output logic [31:0] val);
		@(negedge clk);
		cfg_sel = sel;
		#SAMPLE_DLY;
		val = cfg_rdata;
	endtask

	// bare-mode write that also updates the model
	task automatic write_phys(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [1:0] resp;
		cpu_write(addr, data, strb, resp);
		check_eq("in_bresp", addr, 32'(mmu_pkg::OKAY), 32'(resp));
		shadow[word_idx(addr)] = merge_strb(shadow[word_idx(addr)], data, strb);
	endtask

	task automatic init_word(input logic [31:0] addr, input logic [31:0] data);
		write_phys(addr, data, 4'hF);
		known_addrs.push_back(addr);
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [31:0] va;
		logic [31:0] pa;
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] got;
		logic [3:0]  strb;
		logic [1:0]  resp;
		lcg_state     = 32'd31;
		errors        = 0;
		faults_issued = 0;
		clk        = 1'b0;
		rst        = 1'b1;
		in_araddr  = '0;
		in_arvalid = 1'b0;
		in_rready  = 1'b0;
		in_awaddr  = '0;
		in_awvalid = 1'b0;
		in_wdata   = '0;
		in_wstrb   = '0;
		in_wvalid  = 1'b0;
		in_bready  = 1'b0;
		cfg_we     = 1'b0;
		cfg_sel    = mmu_pkg::REG_SATP;
		cfg_wdata  = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// root entry 0 valid and entry 1 invalid
		// l2 entries 0 to 3 valid and entry 4 invalid
		init_word({ROOT_PPN, 12'h000}, {2'b00, L2_PPN, 10'h001});
		init_word({ROOT_PPN, 12'h004}, {2'b00, 20'd3, 10'h000});
		for (int i = 0; i < 5; i++) begin
			if (i < 4)
				init_word({L2_PPN, 10'(i), 2'b00}, {2'b00, DATA_PPN + 20'(i), 10'h001});
			else
				init_word({L2_PPN, 10'(i), 2'b00}, {2'b00, 20'd5, 10'h000});
		end
		for (int i = 0; i < 4 * FILL_WORDS; i++)
			init_word(data_paddr({22'd0, 2'(i / FILL_WORDS), 1'b0, 5'(i), 2'b00}), next_rand());

		// strobed writes then reads in bare mode
		for (int i = 0; i < N_BARE; i++) begin
			pa   = data_paddr(next_rand());
			d    = next_rand();
			strb = 4'(next_rand());
			write_phys(pa, d, strb);
			cpu_read(pa, got, resp);
			check_eq("in_rdata", pa, shadow[word_idx(pa)], got);
			check_eq("in_rresp", pa, 32'(mmu_pkg::OKAY), 32'(resp));
		end

		cfg_write(mmu_pkg::REG_SATP, SATP_ON);
		cfg_read(mmu_pkg::REG_SATP, got);
		check_eq("cfg_rdata", 32'h0, SATP_ON, got);

		// translated reads
		for (int i = 0; i < N_TRD; i++) begin
			va = mapped_vaddr(next_rand());
			void'(translate(va, pa));
			cpu_read(va, got, resp);
			check_eq("in_rdata", va, shadow[word_idx(pa)], got);
			check_eq("in_rresp", va, 32'(mmu_pkg::OKAY), 32'(resp));
		end

		// translated writes checked later through bare reads
		for (int i = 0; i < N_TWR; i++) begin
			va   = mapped_vaddr(next_rand());
			d    = next_rand();
			strb = 4'(next_rand());
			void'(translate(va, pa));
			cpu_write(va, d, strb, resp);
			check_eq("in_bresp", va, 32'(mmu_pkg::OKAY), 32'(resp));
			shadow[word_idx(pa)] = merge_strb(shadow[word_idx(pa)], d, strb);
			written_pa.push_back(pa);
		end
		cfg_write(mmu_pkg::REG_SATP, 32'h0);
		foreach (written_pa[i]) begin
			cpu_read(written_pa[i], got, resp);
			check_eq("in_rdata", written_pa[i], shadow[word_idx(written_pa[i])], got);
		end

		// faults at either level with reads and writes mixed
		cfg_write(mmu_pkg::REG_SATP, SATP_ON);
		for (int i = 0; i < N_FAULT; i++) begin
			r  = next_rand();
			va = r[0] ? {10'd1, 8'd0, r[9:8], 12'h0} : {10'd0, 10'd4, 12'h0};
			va[6:2] = r[14:10];
			if (r[1]) begin
				cpu_write(va, next_rand(), 4'hF, resp);
				check_eq("in_bresp", va, 32'(mmu_pkg::SLVERR), 32'(resp));
			end else begin
				cpu_read(va, got, resp);
				check_eq("in_rresp", va, 32'(mmu_pkg::SLVERR), 32'(resp));
			end
			faults_issued++;
		end
		cfg_read(mmu_pkg::REG_FAULTS, got);
		check_eq("cfg_rdata", 32'h0, 32'(faults_issued), got);

		// every initialized word must still match the model
		cfg_write(mmu_pkg::REG_SATP, 32'h0);
		foreach (known_addrs[i]) begin
			cpu_read(known_addrs[i], got, resp);
			check_eq("in_rdata", known_addrs[i], shadow[word_idx(known_addrs[i])], got);
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
